/* verilog/sine_tone_consts.svh */
/*
 * Widths, settings register addresses and CORDIC depth for the sine tone
 * generator. Include wherever these values are needed.
 */
`ifndef SINE_TONE_CONSTS_SVH
`define SINE_TONE_CONSTS_SVH

// Phase word, 65536 counts per full turn
`define TONE_PHASE_W 16

// Signed I and Q component width
`define TONE_COMP_W 16

`define TONE_LEN_W 16     // Packet length register

// Settings bus
`define TONE_SET_AW 8
`define TONE_SET_DW 32

// Register map
`define TONE_SR_FREQ      128   // Phase increment
`define TONE_SR_CARTESIAN 130   // Start vector, q high and i low
`define TONE_SR_ENABLE    132
`define TONE_SR_LEN       134   // Samples per packet

`define TONE_CORDIC_ITERS 14   // Micro-rotations after the quadrant stage

`endif

/* verilog/sine_tone_pkg.sv */
/*
 * Shared types of the sine tone generator and the CORDIC arctangent table.
 * Used by the RTL and by the testbench reference model.
 */
`default_nettype none

`include "sine_tone_consts.svh"

package sine_tone_pkg;

  // Unsigned phase, a full turn is 2**TONE_PHASE_W
  typedef logic [`TONE_PHASE_W-1:0] phase_t;

  // Start vector and output sample share one layout
  typedef struct packed {
    logic signed [`TONE_COMP_W-1:0] q;   // Upper half of the bus word
    logic signed [`TONE_COMP_W-1:0] i;   // Lower half
  } iq_t;

  // Rounded atan(2**-n) in phase units
  localparam phase_t cordic_atan [0:`TONE_CORDIC_ITERS-1] = '{
    16'd8192, 16'd4836, 16'd2555, 16'd1297,
    16'd651,  16'd326,  16'd163,  16'd81,
    16'd41,   16'd20,   16'd10,   16'd5,
    16'd3,    16'd1
  };

endpackage

`default_nettype wire

/* verilog/tone_stream_if.sv */
/*
 * Valid/ready stream with a last marker, one word of payload_t per transfer.
 * The source drives data, last and valid; the sink drives ready.
 */
`timescale 1ns/1ps
`default_nettype none

interface tone_stream_if #(
  parameter type payload_t = logic
) ();

  payload_t tdata;
  logic     tlast;   // Final word of a packet
  logic     tvalid;
  logic     tready;

  // Data and last held while valid waits for ready
  modport source (output tdata, output tlast, output tvalid, input tready);

  modport sink (input tdata, input tlast, input tvalid, output tready);

endinterface

`default_nettype wire

/* verilog/tone_settings.sv */
/*
 * Settings bus register file for the tone generator.
 * A strobed write to a matching address updates its register on the next edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "sine_tone_consts.svh"

module tone_settings (
  input  wire                       clk,
  input  wire                       i_reset,
  input  wire                       i_set_stb,
  input  wire [`TONE_SET_AW-1:0]    i_set_addr,
  input  wire [`TONE_SET_DW-1:0]    i_set_data,
  output logic                      o_enable,
  output sine_tone_pkg::phase_t     o_phase_inc,
  output sine_tone_pkg::iq_t        o_start_vec,
  output logic [`TONE_LEN_W-1:0]    o_pkt_len
);

  import sine_tone_pkg::*;

  logic                   wr_freq;
  logic                   wr_cart;
  logic                   wr_enable;
  logic                   wr_len;
  logic [`TONE_LEN_W-1:0] len_data;

  // Address decode
  assign wr_freq   = i_set_stb && (i_set_addr == `TONE_SET_AW'(`TONE_SR_FREQ));
  assign wr_cart   = i_set_stb && (i_set_addr == `TONE_SET_AW'(`TONE_SR_CARTESIAN));
  assign wr_enable = i_set_stb && (i_set_addr == `TONE_SET_AW'(`TONE_SR_ENABLE));
  assign wr_len    = i_set_stb && (i_set_addr == `TONE_SET_AW'(`TONE_SR_LEN));

  assign len_data = i_set_data[`TONE_LEN_W-1:0];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_enable    <= 1'b0;
      o_phase_inc <= '0;
      o_start_vec <= '0;
      o_pkt_len   <= `TONE_LEN_W'(1);
    end else begin
      if (wr_enable) begin
        o_enable <= i_set_data[0];
      end
      if (wr_freq) begin
        o_phase_inc <= i_set_data[`TONE_PHASE_W-1:0];
      end
      if (wr_cart) begin
        o_start_vec <= iq_t'(i_set_data[2*`TONE_COMP_W-1:0]);   // q high, i low
      end
      if (wr_len) begin
        // Zero length would never raise tlast
        o_pkt_len <= (len_data == '0) ? `TONE_LEN_W'(1) : len_data;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/phase_accum.sv */
/*
 * Phase accumulator. Issues one phase per accepted sample, starting at zero
 * after reset or clear, with tlast on every packet-length-th sample.
 */
`timescale 1ns/1ps
`default_nettype none

`include "sine_tone_consts.svh"

module phase_accum (
  input  wire                       clk,
  input  wire                       i_reset,
  input  wire                       i_clear,
  input  wire                       i_enable,
  input  sine_tone_pkg::phase_t     i_phase_inc,
  input  wire [`TONE_LEN_W-1:0]     i_pkt_len,
  tone_stream_if.source             o_phase
);

  import sine_tone_pkg::*;

  phase_t                 phase_r;
  logic [`TONE_LEN_W-1:0] count_r;   // Samples sent in the current packet
  logic                   vld_r;
  logic                   xfer;
  logic                   last;

  assign xfer = vld_r && o_phase.tready;

  // Final sample of the packet
  assign last = (count_r == i_pkt_len - `TONE_LEN_W'(1));

  assign o_phase.tdata  = phase_r;
  assign o_phase.tlast  = last;
  assign o_phase.tvalid = vld_r;

  always_ff @(posedge clk) begin
    if (i_reset || i_clear) begin
      vld_r   <= 1'b0;
      phase_r <= '0;
      count_r <= '0;
    end else begin
      // Valid may only change once the pending sample is taken
      if (!vld_r || xfer) begin
        vld_r <= i_enable;
      end

      if (xfer) begin
        phase_r <= phase_r + i_phase_inc;   // Wraps modulo one turn
        if (last) begin
          count_r <= '0;
        end else begin
          count_r <= count_r + `TONE_LEN_W'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/cordic_rotator.sv */
/*
 * Pipelined CORDIC that rotates the start vector by each incoming phase.
 * One quadrant stage, then one micro-rotation per stage; all stages stall together.
 */
`timescale 1ns/1ps
`default_nettype none

`include "sine_tone_consts.svh"

module cordic_rotator (
  input  wire                       clk,
  input  wire                       i_reset,
  input  sine_tone_pkg::iq_t        i_start_vec,
  tone_stream_if.sink               i_phase,
  tone_stream_if.source             o_sample
);

  import sine_tone_pkg::*;

  localparam int CW    = `TONE_COMP_W;
  localparam int PW    = `TONE_PHASE_W;
  localparam int IW    = `TONE_COMP_W + 2;   // Headroom for gain and quadrant
  localparam int ITERS = `TONE_CORDIC_ITERS;

  logic signed [IW-1:0] x_r [0:ITERS];
  logic signed [IW-1:0] y_r [0:ITERS];
  logic signed [PW-1:0] z_r [0:ITERS-1];   // Residual angle
  logic [ITERS:0]       vld_r;
  logic [ITERS:0]       last_r;

  logic                 advance;
  logic signed [IW-1:0] x_ext;
  logic signed [IW-1:0] y_ext;
  logic signed [IW-1:0] x_pre;
  logic signed [IW-1:0] y_pre;
  logic signed [PW-1:0] z_pre;

  // Clamp back to the output width
  function automatic logic signed [CW-1:0] sat(input logic signed [IW-1:0] v);
    logic all_ones;
    logic all_zeros;
    all_ones  = &v[IW-1:CW-1];
    all_zeros = ~|v[IW-1:CW-1];
    if (all_ones || all_zeros) begin
      return v[CW-1:0];
    end else if (v[IW-1]) begin
      return {1'b1, {(CW-1){1'b0}}};
    end else begin
      return {1'b0, {(CW-1){1'b1}}};
    end
  endfunction

  // Whole pipeline moves when the output slot frees up
  assign advance        = !vld_r[ITERS] || o_sample.tready;
  assign i_phase.tready = advance;

  // Quadrant pre-rotation from the top two phase bits
  always_comb begin
    x_ext = {{2{i_start_vec.i[CW-1]}}, i_start_vec.i};
    y_ext = {{2{i_start_vec.q[CW-1]}}, i_start_vec.q};
    z_pre = {2'b00, i_phase.tdata[PW-3:0]};   // Left within a quarter turn
    case (i_phase.tdata[PW-1 -: 2])
      2'd0: begin
        x_pre = x_ext;
        y_pre = y_ext;
      end
      2'd1: begin   // +90 degrees
        x_pre = -y_ext;
        y_pre = x_ext;
      end
      2'd2: begin
        x_pre = -x_ext;
        y_pre = -y_ext;
      end
      default: begin   // -90 degrees
        x_pre = y_ext;
        y_pre = -x_ext;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      vld_r <= '0;
    end else if (advance) begin
      vld_r <= {vld_r[ITERS-1:0], i_phase.tvalid};
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      x_r[0] <= x_pre;
      y_r[0] <= y_pre;
      z_r[0] <= z_pre;
      last_r <= {last_r[ITERS-1:0], i_phase.tlast};

      for (int n = 0; n < ITERS; n++) begin
        if (!z_r[n][PW-1]) begin   // Residual positive, turn counterclockwise
          x_r[n+1] <= x_r[n] - (y_r[n] >>> n);
          y_r[n+1] <= y_r[n] + (x_r[n] >>> n);
        end else begin
          x_r[n+1] <= x_r[n] + (y_r[n] >>> n);
          y_r[n+1] <= y_r[n] - (x_r[n] >>> n);
        end
      end

      // Last micro-rotation leaves no residual behind it
      for (int n = 0; n < ITERS - 1; n++) begin
        if (!z_r[n][PW-1]) begin
          z_r[n+1] <= z_r[n] - $signed(cordic_atan[n]);
        end else begin
          z_r[n+1] <= z_r[n] + $signed(cordic_atan[n]);
        end
      end
    end
  end

  assign o_sample.tdata.i = sat(x_r[ITERS]);
  assign o_sample.tdata.q = sat(y_r[ITERS]);
  assign o_sample.tlast   = last_r[ITERS];
  assign o_sample.tvalid  = vld_r[ITERS];

endmodule

`default_nettype wire

/* verilog/sine_tone.sv */
/*
 * Sine tone generator top level. Settings bus in, I/Q sample stream out,
 * with q in the upper half of o_tdata and i in the lower half.
 */
`timescale 1ns/1ps
`default_nettype none

`include "sine_tone_consts.svh"

module sine_tone (
  input  wire                        clk,
  input  wire                        i_reset,
  input  wire                        i_clear,    // Restart phase and packet count
  input  wire                        i_set_stb,
  input  wire [`TONE_SET_AW-1:0]     i_set_addr,
  input  wire [`TONE_SET_DW-1:0]     i_set_data,
  output logic [2*`TONE_COMP_W-1:0]  o_tdata,
  output logic                       o_tlast,
  output logic                       o_tvalid,
  input  wire                        i_tready
);

  import sine_tone_pkg::*;

  logic                   enable;
  phase_t                 phase_inc;
  iq_t                    start_vec;
  logic [`TONE_LEN_W-1:0] pkt_len;

  tone_stream_if #(.payload_t(phase_t)) phase_s ();
  tone_stream_if #(.payload_t(iq_t))    sample_s ();

  tone_settings u_settings (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .o_enable    (enable),
    .o_phase_inc (phase_inc),
    .o_start_vec (start_vec),
    .o_pkt_len   (pkt_len)
  );

  phase_accum u_phase_accum (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_clear     (i_clear),
    .i_enable    (enable),
    .i_phase_inc (phase_inc),
    .i_pkt_len   (pkt_len),
    .o_phase     (phase_s.source)
  );

  cordic_rotator u_cordic (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_start_vec (start_vec),
    .i_phase     (phase_s.sink),
    .o_sample    (sample_s.source)
  );

  // Output stream onto plain ports
  assign o_tdata         = sample_s.tdata;   // Packed as {q, i}
  assign o_tlast         = sample_s.tlast;
  assign o_tvalid        = sample_s.tvalid;
  assign sample_s.tready = i_tready;

endmodule

`default_nettype wire

/* dv/tb_sine_tone.sv */
/*
 * Random testbench for the sine tone generator. Writes settings, drives ready,
 * and checks every output sample against a CORDIC reference model.
 */
`timescale 1ns/1ps
`default_nettype none

`include "sine_tone_consts.svh"

module tb_sine_tone;

  import sine_tone_pkg::*;

  localparam int TOTAL_SAMPLES   = 40 + 200 + 60 + 4 * 80;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 8 + 2000;
  localparam int MAX_EXTRA       = `TONE_CORDIC_ITERS + 4;   // Queued stages plus issue to disable
  localparam int MIN_EXTRA       = `TONE_CORDIC_ITERS + 1;   // Queued stages plus the held phase

  logic                      clk;
  logic                      i_reset;
  logic                      i_clear;
  logic                      i_set_stb;
  logic [`TONE_SET_AW-1:0]   i_set_addr;
  logic [`TONE_SET_DW-1:0]   i_set_data;
  logic [2*`TONE_COMP_W-1:0] o_tdata;
  logic                      o_tlast;
  logic                      o_tvalid;
  logic                      i_tready;

  logic [15:0]        lfsr_state = 16'd14197;
  logic               stall_mode;
  string              test_name;
  logic [32:0]        exp_q [$];   // {tlast, q, i}
  logic [32:0]        exp_word;
  int                 rx_count;
  int                 data_errs;
  int                 last_errs;
  int                 proto_errs;
  logic               hold_pending;
  logic [31:0]        hold_data;
  logic               hold_last;

  // Model state, sample index since the last clear
  int                 m_index;
  phase_t             m_inc;
  iq_t                m_vec;
  int                 m_len;

  sine_tone u_dut (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_clear    (i_clear),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_tdata    (o_tdata),
    .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid),
    .i_tready   (i_tready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic int rand_bits(input int n);
    int v;
    logic lsb;
    v = 0;
    for (int b = 0; b < n; b++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) lfsr_state = lfsr_state ^ 16'hB400;
      v = (v << 1) | int'(lsb);
    end
    return v;
  endfunction

  // Component magnitude below 6000 keeps the vector under 9000
  function automatic logic [15:0] rand_comp();
    int mag;
    mag = rand_bits(13) % 6000;
    if (rand_bits(1) != 0) mag = -mag;
    return mag[15:0];
  endfunction

  function automatic logic [15:0] clamp16(input int v);
    if (v > 32767) return 16'h7FFF;
    if (v < -32768) return 16'h8000;
    return v[15:0];
  endfunction

  // Quarter-turn pre-rotation, then 14 shift-and-add steps toward zero residual
  function automatic logic [31:0] rotate_model(input iq_t vec, input phase_t ph);
    int x;
    int y;
    int z;
    int xt;
    x = int'($signed(vec.i));
    y = int'($signed(vec.q));
    case (ph[15:14])
      2'd1: begin
        xt = x;
        x = -y;
        y = xt;
      end
      2'd2: begin
        x = -x;
        y = -y;
      end
      2'd3: begin
        xt = x;
        x = y;
        y = -xt;
      end
      default: ;
    endcase
    z = int'(ph[13:0]);
    for (int k = 0; k < `TONE_CORDIC_ITERS; k++) begin
      xt = x;
      if (z >= 0) begin
        x = x - (y >>> k);
        y = y + (xt >>> k);
        z = z - int'(cordic_atan[k]);
      end else begin
        x = x + (y >>> k);
        y = y - (xt >>> k);
        z = z + int'(cordic_atan[k]);
      end
    end
    return {clamp16(y), clamp16(x)};
  endfunction

  // Next sample the generator should issue
  task automatic issue_expected();
    phase_t ph;
    logic   last;
    ph   = phase_t'(m_index * int'(m_inc));
    last = ((m_index + 1) % m_len) == 0;
    exp_q.push_back({last, rotate_model(m_vec, ph)});
    m_index++;
  endtask

  task automatic write_setting(input int addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    i_set_stb  = 1'b1;
    i_set_addr = addr[`TONE_SET_AW-1:0];
    i_set_data = data;
    @(posedge clk);
    #1;
    i_set_stb  = 1'b0;
  endtask

  task automatic configure(input phase_t inc, input iq_t vec, input int len);
    write_setting(`TONE_SR_FREQ, {16'd0, inc});
    write_setting(`TONE_SR_CARTESIAN, vec);
    write_setting(`TONE_SR_LEN, len);
    m_inc = inc;
    m_vec = vec;
    m_len = len;
  endtask

  task automatic clear_pulse();
    @(posedge clk);
    #1 i_clear = 1'b1;
    @(posedge clk);
    #1 i_clear = 1'b0;
    m_index = 0;
  endtask

  // Enable for n samples, then disable and wait for the pipeline to empty
  task automatic run_samples(input int n, input logic stall);
    int target;
    int quiet;
    stall_mode = stall;
    repeat (n) issue_expected();
    target = rx_count + n;
    write_setting(`TONE_SR_ENABLE, 32'd1);
    while (rx_count < target) @(posedge clk);
    write_setting(`TONE_SR_ENABLE, 32'd0);
    quiet = 0;
    while (quiet < 40) begin
      @(negedge clk);
      quiet = o_tvalid ? 0 : quiet + 1;
    end
    if (rx_count - target > MAX_EXTRA) begin
      proto_errs++;
      $display("%s: %0d samples arrived after disable", test_name, rx_count - target);
    end
    if (rx_count - target < MIN_EXTRA) begin
      proto_errs++;
      $display("%s: only %0d samples arrived after disable, in-flight samples lost",
               test_name, rx_count - target);
    end
  endtask

  // Ready with about a third of cycles stalled
  always @(posedge clk) begin
    #1;
    if (stall_mode) i_tready = rand_bits(3) >= 3;
    else i_tready = 1'b1;
  end

  // Output monitor, sampled mid-cycle where everything is stable
  always @(negedge clk) begin
    if (!i_reset) begin
      if (hold_pending && (!o_tvalid || o_tdata != hold_data || o_tlast != hold_last)) begin
        proto_errs++;
        $display("%s: output changed while stalled", test_name);
      end
      hold_pending = 1'b0;
      if (o_tvalid && i_tready) begin
        if (exp_q.size() == 0) issue_expected();   // Sample issued during drain
        exp_word = exp_q.pop_front();
        if (o_tdata != exp_word[31:0]) begin
          data_errs++;
          $display("CHECK FAILED %s sample %0d tdata: expected %h actual %h",
                   test_name, rx_count, exp_word[31:0], o_tdata);
        end
        if (o_tlast != exp_word[32]) begin
          last_errs++;
          $display("CHECK FAILED %s sample %0d tlast: expected %b actual %b",
                   test_name, rx_count, exp_word[32], o_tlast);
        end
        rx_count++;
      end else if (o_tvalid) begin
        hold_pending = 1'b1;
        hold_data    = o_tdata;
        hold_last    = o_tlast;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, %0d samples received",
             WATCHDOG_CYCLES, rx_count);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    i_reset      = 1'b1;
    i_clear      = 1'b0;
    i_set_stb    = 1'b0;
    i_set_addr   = '0;
    i_set_data   = '0;
    i_tready     = 1'b1;
    stall_mode   = 1'b0;
    rx_count     = 0;
    data_errs    = 0;
    last_errs    = 0;
    proto_errs   = 0;
    hold_pending = 1'b0;
    m_index      = 0;
    m_len        = 1;
    repeat (3) @(posedge clk);
    #1 i_reset = 1'b0;

    test_name = "idle";
    repeat (50) begin
      @(negedge clk);
      if (o_tvalid) begin
        proto_errs++;
        $display("idle: o_tvalid high before enable was written");
      end
    end

    // Randoms drawn at negedge, away from the ready process
    test_name = "quadrant_walk";
    @(negedge clk);
    configure(16'd16384, {rand_comp(), rand_comp()}, rand_bits(4) + 1);
    clear_pulse();
    run_samples(40, 1'b0);

    test_name = "steady";
    @(negedge clk);
    configure(phase_t'(rand_bits(16)), {rand_comp(), rand_comp()}, rand_bits(4) + 1);
    clear_pulse();
    run_samples(200, 1'b0);

    test_name = "resume";   // No clear, phase and count carry on
    run_samples(60, 1'b1);

    for (int r = 0; r < 4; r++) begin
      test_name = "backpressure";
      @(negedge clk);
      configure(phase_t'(rand_bits(16)), {rand_comp(), rand_comp()},
                (r == 0) ? 1 : rand_bits(4) + 1);
      clear_pulse();
      run_samples(80, 1'b1);
    end

    $display("Samples %0d, errors: tdata %0d, tlast %0d, protocol %0d",
             rx_count, data_errs, last_errs, proto_errs);
    if (data_errs + last_errs + proto_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/sine_tone_pkg.sv
verilog/tone_stream_if.sv
verilog/tone_settings.sv
verilog/phase_accum.sv
verilog/cordic_rotator.sv
verilog/sine_tone.sv
dv/tb_sine_tone.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the sine tone testbench with Verilator, run it, and check the log.

cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -j 0 \
  --top-module tb_sine_tone \
  -f compile.f \
  -o tb_sine_tone &&
./obj_dir/tb_sine_tone | tee sim.log &&
grep -q "^RESULT: PASS$" sim.log &&
echo "Simulation passed" ||
{
  echo "Simulation failed"
  exit 1
}
